// File: hw/ic_pkg.sv
// instruction cache shared definitions
// geometry, field widths, response codes and FSM state types
`default_nettype none

package ic_pkg;

    // 2-way, 256 sets, 8-byte lines = 4 KB
    localparam int NUM_SETS = 256;

    localparam logic [1:0]  RESP_OKAY = 2'b00;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_INST  = 32'h0000_0013;

    // fetch address split: tag [31:11], index [10:3], word [2]
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [63:0] beat_t;
    typedef logic [20:0] tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [1:0]  resp_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_HIT_READ,
        CTRL_MISS_WAIT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_ADDR,
        MISS_DATA
    } miss_state_e;

endpackage

`default_nettype wire

// File: hw/ic_fill_if.sv
// line fill path from the miss unit into the tag and data stores
`timescale 1ns/1ps
`default_nettype none

interface ic_fill_if;
    import ic_pkg::*;

    logic   fill_valid;
    index_t fill_index;
    tag_t   fill_tag;
    beat_t  fill_data;
    // victim way chosen by the tag store at miss start
    logic   fill_way;

    modport miss (
        output fill_valid, fill_index, fill_tag, fill_data
    );

    modport tag (
        input  fill_valid, fill_index, fill_tag, fill_data,
        output fill_way
    );

    modport data (
        input fill_valid, fill_index, fill_data, fill_way
    );

endinterface

`default_nettype wire

// File: hw/ic_fetch_ctrl.sv
// fetch control for the instruction cache
// splits the pc, decides hit or miss and drives the instruction outputs
`timescale 1ns/1ps
`default_nettype none

module ic_fetch_ctrl (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire ic_pkg::addr_t pc,
    input  wire logic          stall,
    input  wire logic          flush,
    input  wire logic          hit,
    input  wire logic          hit_way,
    input  wire ic_pkg::inst_t rd_inst,
    input  wire logic          miss_done,
    input  wire ic_pkg::inst_t miss_inst,
    output ic_pkg::index_t     lk_index,
    output ic_pkg::tag_t       lk_tag,
    output logic               rd_en,
    output logic               rd_word_hi,
    output logic               miss_start,
    output ic_pkg::addr_t      miss_addr,
    output ic_pkg::inst_t      inst,
    output logic               inst_valid
);
    import ic_pkg::*;

    ctrl_state_e state;
    logic        flush_go;
    logic        lookup_go;

    assign flush_go  = flush && !stall;
    assign lookup_go = (state == CTRL_IDLE) && !stall && !flush;

    assign lk_index   = pc[10:3];
    assign lk_tag     = pc[31:11];
    assign rd_word_hi = pc[2];
    assign miss_addr  = pc;

    assign rd_en      = lookup_go && hit;
    assign miss_start = lookup_go && !hit;

    always_ff @(posedge clk) begin
        if (rst || flush_go) begin
            state      <= CTRL_IDLE;
            inst       <= NOP_INST;
            inst_valid <= 1'b1;
        end else begin
            unique case (state)
                CTRL_IDLE: begin
                    if (!stall) begin
                        inst_valid <= 1'b0;
                        state      <= hit ? CTRL_HIT_READ : CTRL_MISS_WAIT;
                    end
                end
                // data store word is registered by now
                CTRL_HIT_READ: begin
                    inst       <= rd_inst;
                    inst_valid <= 1'b1;
                    state      <= CTRL_IDLE;
                end
                CTRL_MISS_WAIT: begin
                    if (miss_done) begin
                        inst       <= miss_inst;
                        inst_valid <= 1'b1;
                        state      <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // the miss unit only completes a miss this side is waiting for
    a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
        miss_done |-> state == CTRL_MISS_WAIT);

endmodule

`default_nettype wire

// File: hw/ic_tag_store.sv
// tag, valid and victim arrays of the two-way instruction cache
// combinational lookup, victim pick at miss start, tag write on fill
`timescale 1ns/1ps
`default_nettype none

module ic_tag_store (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire ic_pkg::index_t lk_index,
    input  wire ic_pkg::tag_t   lk_tag,
    input  wire logic           miss_start,
    output logic                hit,
    output logic                hit_way,
    ic_fill_if.tag              fill
);
    import ic_pkg::*;

    tag_t                     tag_mem [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0]      victim_q;

    logic hit0;
    logic hit1;
    logic next_victim;

    // ======================================================================
    // lookup
    // ======================================================================

    assign hit0    = valid_q[0][lk_index] && (tag_mem[0][lk_index] == lk_tag);
    assign hit1    = valid_q[1][lk_index] && (tag_mem[1][lk_index] == lk_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    // ======================================================================
    // victim choice and fill
    // ======================================================================

    // empty way first, else alternate
    always_comb begin
        if (!valid_q[0][lk_index]) begin
            next_victim = 1'b0;
        end else if (!valid_q[1][lk_index]) begin
            next_victim = 1'b1;
        end else begin
            next_victim = ~victim_q[lk_index];
        end
    end

    // only one miss is in flight, so the set's victim bit is still the one picked
    assign fill.fill_way = victim_q[fill.fill_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            if (miss_start) begin
                victim_q[lk_index] <= next_victim;
            end
            if (fill.fill_valid) begin
                valid_q[fill.fill_way][fill.fill_index] <= 1'b1;
            end
        end
    end

    // tag payload
    always_ff @(posedge clk) begin
        if (fill.fill_valid) begin
            tag_mem[fill.fill_way][fill.fill_index] <= fill.fill_tag;
        end
    end

    // a line is only filled after missing in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        !(hit0 && hit1));

endmodule

`default_nettype wire

// File: hw/ic_data_store.sv
// line data array of the instruction cache
// one-cycle registered word read, whole-line write on fill
`timescale 1ns/1ps
`default_nettype none

module ic_data_store (
    input  wire logic           clk,
    input  wire logic           rd_en,
    input  wire ic_pkg::index_t rd_index,
    input  wire logic           rd_way,
    input  wire logic           rd_word_hi,
    output ic_pkg::inst_t       rd_inst,
    ic_fill_if.data             fill
);
    import ic_pkg::*;

    beat_t line_mem [2][NUM_SETS];
    beat_t rd_line;

    assign rd_line = line_mem[rd_way][rd_index];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_inst <= rd_word_hi ? rd_line[63:32] : rd_line[31:0];
        end
        if (fill.fill_valid) begin
            line_mem[fill.fill_way][fill.fill_index] <= fill.fill_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/ic_miss_unit.sv
// miss handling for the instruction cache
// single-beat AXI read of the missing line, then the line fill
`timescale 1ns/1ps
`default_nettype none

module ic_miss_unit (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  wire logic          stall,
    input  wire logic          miss_start,
    input  wire ic_pkg::addr_t miss_addr,
    input  wire logic          arready,
    input  wire logic          rvalid,
    input  wire ic_pkg::beat_t rdata,
    input  wire ic_pkg::resp_t rresp,
    output logic               arvalid,
    output ic_pkg::addr_t      araddr,
    output logic               rready,
    output logic               miss_done,
    output ic_pkg::inst_t      miss_inst,
    output logic               miss_err,
    ic_fill_if.miss            fill
);
    import ic_pkg::*;

    miss_state_e state;
    logic        word_hi_q;
    logic        flush_go;
    logic        beat_take;

    assign flush_go  = flush && !stall;
    assign arvalid   = (state == MISS_ADDR);
    assign rready    = (state == MISS_DATA);
    assign beat_take = rready && rvalid;

    assign miss_done = beat_take;
    assign miss_inst = word_hi_q ? rdata[63:32] : rdata[31:0];

    assign fill.fill_valid = beat_take;
    assign fill.fill_index = araddr[10:3];
    assign fill.fill_tag   = araddr[31:11];
    assign fill.fill_data  = rdata;

    always_ff @(posedge clk) begin
        if (rst || flush_go) begin
            state <= MISS_IDLE;
        end else begin
            unique case (state)
                MISS_IDLE: if (miss_start) state <= MISS_ADDR;
                MISS_ADDR: if (arready)    state <= MISS_DATA;
                MISS_DATA: if (rvalid)     state <= MISS_IDLE;
                default:                   state <= MISS_IDLE;
            endcase
        end
    end

    // request address, line aligned
    always_ff @(posedge clk) begin
        if (state == MISS_IDLE && miss_start) begin
            araddr    <= {miss_addr[31:3], 3'b000};
            word_hi_q <= miss_addr[2];
        end
    end

    // sticky until the next beat lands
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_err <= 1'b0;
        end else if (beat_take) begin
            miss_err <= (rresp != RESP_OKAY);
        end
    end

    // request held until the interconnect takes it
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready && !flush_go |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// instruction cache top level
// fetch control, tag and data stores and the AXI miss unit
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire ic_pkg::addr_t pc,
    input  wire logic          stall,
    input  wire logic          flush,
    input  wire logic          arready,
    input  wire logic          rvalid,
    input  wire ic_pkg::beat_t rdata,
    input  wire ic_pkg::resp_t rresp,
    output logic               arvalid,
    output ic_pkg::addr_t      araddr,
    output logic               rready,
    output ic_pkg::inst_t      inst,
    output logic               inst_valid,
    output logic               err
);
    import ic_pkg::*;

    index_t lk_index;
    tag_t   lk_tag;
    logic   hit;
    logic   hit_way;
    logic   rd_en;
    logic   rd_word_hi;
    inst_t  rd_inst;
    logic   miss_start;
    addr_t  miss_addr;
    logic   miss_done;
    inst_t  miss_inst;

    ic_fill_if u_fill_if ();

    ic_fetch_ctrl u_fetch_ctrl (
        .clk, .rst, .pc, .stall, .flush,
        .hit, .hit_way, .rd_inst, .miss_done, .miss_inst,
        .lk_index, .lk_tag, .rd_en, .rd_word_hi,
        .miss_start, .miss_addr, .inst, .inst_valid
    );

    ic_tag_store u_tag_store (
        .clk, .rst, .lk_index, .lk_tag, .miss_start,
        .hit, .hit_way,
        .fill (u_fill_if.tag)
    );

    ic_data_store u_data_store (
        .clk, .rd_en,
        .rd_index (lk_index),
        .rd_way   (hit_way),
        .rd_word_hi, .rd_inst,
        .fill     (u_fill_if.data)
    );

    ic_miss_unit u_miss_unit (
        .clk, .rst, .flush, .stall, .miss_start, .miss_addr,
        .arready, .rvalid, .rdata, .rresp,
        .arvalid, .araddr, .rready, .miss_done, .miss_inst,
        .miss_err (err),
        .fill     (u_fill_if.miss)
    );

endmodule

`default_nettype wire

// File: verif/tb_axi_slave.sv
// AXI read responder for the instruction cache testbench
// single-beat line reads with random handshake delays and one error page
`timescale 1ns/1ps
`default_nettype none

module tb_axi_slave #(
    parameter logic [31:0] PATTERN  = 32'h0,
    parameter logic [19:0] ERR_PAGE = 20'h0
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        arvalid,
    input  wire logic [31:0] araddr,
    input  wire logic        rready,
    output logic             arready,
    output logic             rvalid,
    output logic [63:0]      rdata,
    output logic [1:0]       rresp
);
    typedef enum logic [1:0] {
        WAIT_AR,
        DELAY_R,
        SEND_R
    } phase_e;

    phase_e      phase      = WAIT_AR;
    logic [1:0]  delay      = 2'd0;
    logic [31:0] req_addr   = 32'h0;
    logic        ar_ready_q = 1'b0;
    logic        r_valid_q  = 1'b0;
    logic [63:0] r_data_q   = 64'h0;
    logic [1:0]  r_resp_q   = 2'b00;

    assign arready = ar_ready_q;
    assign rvalid  = r_valid_q;
    assign rdata   = r_data_q;
    assign rresp   = r_resp_q;

    always @(posedge clk) begin
        if (rst) begin
            phase      <= WAIT_AR;
            delay      <= 2'd1;
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            case (phase)
                WAIT_AR: begin
                    if (arvalid && ar_ready_q) begin
                        ar_ready_q <= 1'b0;
                        req_addr   <= araddr;
                        delay      <= 2'($urandom);
                        phase      <= DELAY_R;
                    end else if (arvalid) begin
                        if (delay == 2'd0) begin
                            ar_ready_q <= 1'b1;
                        end else begin
                            delay <= delay - 2'd1;
                        end
                    end
                end
                DELAY_R: begin
                    if (delay == 2'd0) begin
                        // upper word is the one at A+4
                        r_valid_q <= 1'b1;
                        r_data_q  <= {(req_addr + 32'd4) ^ PATTERN, req_addr ^ PATTERN};
                        r_resp_q  <= (req_addr[31:12] == ERR_PAGE) ? 2'b10 : 2'b00;
                        phase     <= SEND_R;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                SEND_R: begin
                    if (rready) begin
                        r_valid_q <= 1'b0;
                        delay     <= 2'($urandom);
                        phase     <= WAIT_AR;
                    end
                end
                default: phase <= WAIT_AR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_icache.sv
// testbench for the two-way instruction cache
// drives fetches, tracks a victim model and checks with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import ic_pkg::*;

    localparam logic [31:0] PATTERN  = 32'h5EED_0000;
    localparam logic [19:0] ERR_PAGE = 20'h00008;
    // about 60 fetches at up to ~14 cycles each, plus reset and stall phases
    localparam int TIMEOUT_CYCLES = 4000;

    logic  clk;
    logic  rst   = 1'b1;
    addr_t pc    = 32'h0;
    logic  stall = 1'b1;
    logic  flush = 1'b0;
    logic  arready;
    logic  rvalid;
    beat_t rdata;
    resp_t rresp;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
    inst_t inst;
    logic  inst_valid;
    logic  err;

    // victim model and expectations for the fetch in flight
    logic  model_valid  [2][NUM_SETS];
    tag_t  model_tag    [2][NUM_SETS];
    logic  model_victim [NUM_SETS];
    inst_t exp_inst     = 32'h0;
    logic  exp_hit      = 1'b0;
    logic  exp_err      = 1'b0;
    int    exp_ar_count = 0;
    int    ar_count     = 0;
    int    hit_edges    = 0;
    int    cycles       = 0;
    string test_name    = "reset";

    icache_top u_icache_top (.*);

    tb_axi_slave #(.PATTERN(PATTERN), .ERR_PAGE(ERR_PAGE)) u_axi_slave (
        .clk, .rst, .arvalid, .araddr, .rready, .arready, .rvalid, .rdata, .rresp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic mismatch_fail(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("Fail %s (%s): expected %h, actual %h", test_name, what, exp_v, act_v);
        $display("Simulation failed");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_run(input string what);
        $display("%s during %s", what, test_name);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst) begin
            if (arvalid && arready) ar_count <= ar_count + 1;
            // edges since the accepting edge
            if (inst_valid && !stall && !flush) begin
                hit_edges <= 1;
            end else if (!inst_valid) begin
                hit_edges <= hit_edges + 1;
            end
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ======================================================================
    // checks
    // ======================================================================

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> inst_valid && inst == NOP_INST && !arvalid && !rready && !err)
        else abort_run("outputs not in their reset state after reset");

    a_inst_word: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_valid) |-> inst == exp_inst)
        else mismatch_fail("inst", $sampled(exp_inst), $sampled(inst));

    a_ar_count: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_valid) |-> ar_count == exp_ar_count)
        else mismatch_fail("ar requests", $sampled(exp_ar_count), $sampled(ar_count));

    a_err_flag: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_valid) |-> err == exp_err)
        else mismatch_fail("err", 32'($sampled(exp_err)), 32'($sampled(err)));

    a_hit_edges: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_valid) && exp_hit |-> hit_edges == 2)
        else mismatch_fail("hit edges", 32'd2, $sampled(hit_edges));

    a_hit_no_ar: assert property (@(posedge clk) disable iff (rst)
        !inst_valid && exp_hit |-> !arvalid)
        else abort_run("read request issued for a hit");

    a_araddr: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> araddr == {pc[31:3], 3'b000})
        else mismatch_fail("araddr", {$sampled(pc[31:3]), 3'b000}, $sampled(araddr));

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else abort_run("read request changed before it was accepted");

    a_busy_invalid: assert property (@(posedge clk) disable iff (rst)
        arvalid || rready |-> !inst_valid)
        else abort_run("inst_valid high while a miss is outstanding");

    a_stall_idle: assert property (@(posedge clk) disable iff (rst)
        stall && inst_valid |=> inst_valid && !arvalid)
        else abort_run("fetch started while stalled");

    a_flush_nop: assert property (@(posedge clk) disable iff (rst)
        flush && !stall |=> inst_valid && inst == NOP_INST)
        else mismatch_fail("inst after flush", NOP_INST, $sampled(inst));

    a_flush_blocked: assert property (@(posedge clk) disable iff (rst)
        flush && stall && inst_valid |=> $stable(inst))
        else abort_run("flush applied while stalled");

    // ======================================================================
    // stimulus
    // ======================================================================

    // empty way first, else toggle; returns the expected hit
    function automatic logic model_fetch(input addr_t addr);
        index_t idx;
        tag_t   tg;
        logic   way;
        idx = addr[10:3];
        tg  = addr[31:11];
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tg) return 1'b1;
        end
        if (!model_valid[0][idx]) begin
            way = 1'b0;
        end else if (!model_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = !model_victim[idx];
        end
        model_victim[idx]     = way;
        model_valid[way][idx] = 1'b1;
        model_tag[way][idx]   = tg;
        return 1'b0;
    endfunction

    // one lookup, released by a single low stall edge
    task automatic fetch(input addr_t addr);
        logic hit_now;
        hit_now = model_fetch(addr);
        @(posedge clk);
        pc       <= addr;
        stall    <= 1'b0;
        exp_inst <= addr ^ PATTERN;
        exp_hit  <= hit_now;
        if (!hit_now) begin
            exp_ar_count <= exp_ar_count + 1;
            exp_err      <= (addr[31:12] == ERR_PAGE);
        end
        @(posedge clk);
        stall <= 1'b1;
        do @(posedge clk); while (!inst_valid);
    endtask

    // flush held against a stall, so it must not apply
    task automatic hold_stall(input addr_t addr, input int n);
        @(posedge clk);
        pc    <= addr;
        flush <= 1'b1;
        repeat (n) @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        stall <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b1;
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(21079));
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_victim[s]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        test_name = "cold miss and hit";
        fetch(32'h0000_0104);
        fetch(32'h0000_0100);

        // three tags in set 0x40
        test_name = "two ways and eviction";
        fetch(32'h0000_0A00);
        fetch(32'h0000_1200);
        fetch(32'h0000_0A04);
        fetch(32'h0000_1204);
        fetch(32'h0000_1A00);
        fetch(32'h0000_1200);
        fetch(32'h0000_0A00);

        test_name = "stall and flush";
        hold_stall(32'h0002_0000, 20);
        apply_flush();

        test_name = "error response";
        fetch(32'h0000_8010);
        fetch(32'h0000_8014);
        fetch(32'h0000_3000);

        // 4 tags over 8 sets
        test_name = "back-pressure";
        repeat (50) begin
            rnd = $urandom;
            fetch(32'h0001_0000 | (rnd & 32'h0000_183C));
        end

        repeat (5) @(posedge clk);
        if (ar_count == exp_ar_count) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            mismatch_fail("total ar requests", exp_ar_count, ar_count);
        end
    end

endmodule

`default_nettype wire

// File: all.f
hw/ic_pkg.sv
hw/ic_fill_if.sv
hw/ic_fetch_ctrl.sv
hw/ic_tag_store.sv
hw/ic_data_store.sv
hw/ic_miss_unit.sv
hw/icache_top.sv
verif/tb_axi_slave.sv
verif/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_icache -f all.f -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "result: PASS" \
    || { echo "result: FAIL"; exit 1; }
